/* tb.f */
common/bus_pkg.sv
common/dcache_pkg.sv
common/dcache_array_if.sv
dcache/dcache_arrays.sv
dcache/dcache_ctrl.sv
source/dcache_top.sv
tb/tb_clkgen.sv
tb/bus_mem_model.sv
tb/dcache_tb.sv

/* tb/dcache_tb.sv */
// ==========================================================
// Data cache testbench: applies a table of CPU accesses and
// checks read data and bus beat counts against shadow copies
// ==========================================================
`default_nettype none

module dcache_tb
	import bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// One CPU access with its preparation steps and expected bus beats
	// An exp_wr below zero means the victim is random, so only pairs are checked
	typedef struct packed {
		logic         we;
		cache_attr_t  attr;
		logic         dce;
		logic [31:0]  adr;
		logic         bd;
		logic         snp;
		logic         err;
		int           exp_rd;
		int           exp_wr;
		logic [127:0] wdat;
		logic [127:0] bd_dat;
	} entry_t;

	logic         clk;
	logic         rst;
	logic         dce;
	logic         cpu_cyc;
	logic         cpu_we;
	cache_attr_t  cpu_attr;
	logic [31:0]  cpu_adr;
	logic [127:0] cpu_wdat;
	logic         cpu_ack;
	logic [127:0] cpu_rdat;
	logic         bus_cyc;
	logic         bus_stb;
	logic         bus_we;
	logic [31:0]  bus_adr;
	logic [127:0] bus_wdat;
	logic         bus_ack;
	logic         bus_err;
	logic [127:0] bus_rdat;
	logic         snoop_v;
	logic [31:0]  snoop_adr;
	logic         err_arm;
	logic         bd_we;
	logic [31:0]  bd_adr;
	logic [127:0] bd_dat;
	int           rd_cnt;
	int           wr_cnt;
	int           att_cnt;

	entry_t       tab [64];
	int           n_entries;
	int           checks;
	int           mismatches;
	int           timeouts;
	int           evict_wr;
	logic [31:0]  rng;
	// What the CPU should read, and what the bus memory holds
	logic [127:0] cpu_view [1024];
	logic [127:0] mem_view [1024];

	tb_clkgen clkgen (.clk_o(clk), .rst_o(rst));

	bus_mem_model bus_mem (
		.clk_i(clk), .rst_i(rst), .cyc_i(bus_cyc), .stb_i(bus_stb), .we_i(bus_we),
		.adr_i(bus_adr), .dat_i(bus_wdat), .ack_o(bus_ack), .err_o(bus_err),
		.dat_o(bus_rdat), .err_arm_i(err_arm), .bd_we_i(bd_we), .bd_adr_i(bd_adr),
		.bd_dat_i(bd_dat), .rd_cnt_o(rd_cnt), .wr_cnt_o(wr_cnt), .att_cnt_o(att_cnt)
	);

	dcache_top UUT (
		.clk_i(clk), .rst_i(rst), .dce_i(dce), .cpu_cyc_i(cpu_cyc), .cpu_we_i(cpu_we),
		.cpu_attr_i(cpu_attr), .cpu_adr_i(cpu_adr), .cpu_dat_i(cpu_wdat),
		.cpu_ack_o(cpu_ack), .cpu_dat_o(cpu_rdat), .bus_cyc_o(bus_cyc),
		.bus_stb_o(bus_stb), .bus_we_o(bus_we), .bus_adr_o(bus_adr),
		.bus_dat_o(bus_wdat), .bus_ack_i(bus_ack), .bus_err_i(bus_err),
		.bus_dat_i(bus_rdat), .snoop_v_i(snoop_v), .snoop_adr_i(snoop_adr)
	);

	// ==========================================================
	// Helpers
	// ==========================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Initial memory content of the beat holding a byte address
	function automatic logic [127:0] initial_beat(input logic [31:0] adr);
		logic [31:0] b;
		b = {adr[31:4], 4'h0};
		return {b ^ 32'hC3A5_1E0F, b + 32'h0101_0101, ~b, b};
	endfunction

	// Tag above bit 9, set index in bits 8..5, half in bit 4
	function automatic logic [31:0] beat_address(input int tag, input int idx, input int half);
		return (tag << 9) | (idx << 5) | (half << 4);
	endfunction

	task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("FAIL %0t: %s: got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic draw_word(output logic [127:0] w);
		for (int k = 0; k < 4; k++) begin
			rng = xorshift32(rng);
			w = {w[95:0], rng};
		end
	endtask

	task automatic add_entry(input logic we, input cache_attr_t attr, input logic dce_v,
		input logic [31:0] adr, input logic bd, input logic snp, input logic err,
		input int exp_rd, input int exp_wr);
		entry_t e;
		e.we     = we;
		e.attr   = attr;
		e.dce    = dce_v;
		e.adr    = adr;
		e.bd     = bd;
		e.snp    = snp;
		e.err    = err;
		e.exp_rd = exp_rd;
		e.exp_wr = exp_wr;
		draw_word(e.wdat);
		draw_word(e.bd_dat);
		tab[n_entries] = e;
		n_entries++;
	endtask

	// ==========================================================
	// Stimulus table
	// ==========================================================

	task automatic build_table();
		// Read miss fills set 1, the other half then hits
		add_entry(0, CACHEABLE, 1, beat_address(2, 1, 0), 0, 0, 0, 2, 0);
		add_entry(0, CACHEABLE, 1, beat_address(2, 1, 1), 0, 0, 0, 0, 0);
		// Write hit and readback with no bus traffic
		add_entry(1, CACHEABLE, 1, beat_address(2, 1, 1), 0, 0, 0, 0, 0);
		add_entry(0, CACHEABLE, 1, beat_address(2, 1, 1), 0, 0, 0, 0, 0);
		// Dirty four lines of set 3, push them out, read memory around the cache
		for (int t = 1; t <= 4; t++)
			add_entry(1, CACHEABLE, 1, beat_address(t, 3, 0), 0, 0, 0, 2, -1);
		for (int t = 5; t <= 9; t++)
			add_entry(0, cache_attr_t'((t % 2) ? CACHEABLE_NB : CACHEABLE), 1,
				beat_address(t, 3, 0), 0, 0, 0, 2, -1);
		for (int t = 1; t <= 4; t++)
			add_entry(0, NON_CACHEABLE, 1, beat_address(t, 3, 0), 0, 0, 0, 1, 0);
		// Bypass by attribute and by a disabled cache, after backdoor changes
		add_entry(0, NON_CACHEABLE, 1, beat_address(12, 4, 0), 1, 0, 0, 1, 0);
		add_entry(0, CACHEABLE, 0, beat_address(12, 4, 1), 1, 0, 0, 1, 0);
		add_entry(1, NON_CACHEABLE, 1, beat_address(13, 4, 0), 0, 0, 0, 0, 1);
		add_entry(0, CACHEABLE, 0, beat_address(13, 4, 0), 0, 0, 0, 1, 0);
		// First attempt errors on a bypass beat and on a line fill
		add_entry(0, NON_CACHEABLE, 1, beat_address(14, 6, 0), 0, 0, 1, 1, 0);
		add_entry(0, CACHEABLE, 1, beat_address(15, 7, 1), 0, 0, 1, 2, 0);
		add_entry(0, CACHEABLE, 1, beat_address(15, 7, 0), 0, 0, 0, 0, 0);
		// Snoop drops the stale line of set 1, so the read refetches it
		add_entry(0, CACHEABLE, 1, beat_address(2, 1, 0), 1, 1, 0, 2, 0);
		add_entry(0, CACHEABLE, 1, beat_address(2, 1, 0), 0, 0, 0, 0, 0);
	endtask

	// ==========================================================
	// Applying one entry
	// ==========================================================

	task automatic run_entry(input int i);
		entry_t       e;
		logic [9:0]   bi;
		logic         bypass;
		logic [127:0] exp;
		logic [127:0] got;
		logic         acked;
		int           rd0;
		int           wr0;
		int           att0;
		int           n;
		e      = tab[i];
		bi     = e.adr[13:4];
		bypass = !e.dce || (e.attr == NON_CACHEABLE);
		if (e.bd) begin
			@(posedge clk);
			bd_we  <= 1'b1;
			bd_adr <= e.adr;
			bd_dat <= e.bd_dat;
			@(posedge clk);
			bd_we <= 1'b0;
			cpu_view[bi] = e.bd_dat;
			mem_view[bi] = e.bd_dat;
		end
		if (e.snp) begin
			@(posedge clk);
			snoop_v   <= 1'b1;
			snoop_adr <= e.adr;
			@(posedge clk);
			snoop_v <= 1'b0;
			// An invalidated line is fetched again, any unwritten data is gone
			cpu_view[{bi[9:1], 1'b0}] = mem_view[{bi[9:1], 1'b0}];
			cpu_view[{bi[9:1], 1'b1}] = mem_view[{bi[9:1], 1'b1}];
		end
		if (e.err) begin
			@(posedge clk);
			err_arm <= 1'b1;
			@(posedge clk);
			err_arm <= 1'b0;
		end
		if (e.we) begin
			cpu_view[bi] = e.wdat;
			if (bypass)
				mem_view[bi] = e.wdat;
		end
		exp = bypass ? mem_view[bi] : cpu_view[bi];
		@(negedge clk);
		rd0  = rd_cnt;
		wr0  = wr_cnt;
		att0 = att_cnt;
		@(posedge clk);
		cpu_cyc  <= 1'b1;
		cpu_we   <= e.we;
		cpu_attr <= e.attr;
		dce      <= e.dce;
		cpu_adr  <= e.adr;
		cpu_wdat <= e.wdat;
		// Wait for the acknowledge, sampled away from the clock edge
		n     = 0;
		acked = 1'b0;
		got   = '0;
		while (!acked && n < 2000) begin
			@(negedge clk);
			n++;
			if (cpu_ack) begin
				acked = 1'b1;
				got   = cpu_rdat;
			end
		end
		@(posedge clk);
		cpu_cyc <= 1'b0;
		cpu_we  <= 1'b0;
		@(negedge clk);
		if (!acked) begin
			timeouts++;
			$display("Timeout: entry %0d got no CPU acknowledge within 2000 cycles", i);
		end else if (!e.we) begin
			check_eq(got, exp, $sformatf("entry %0d read data", i));
		end
		if (acked) begin
			// A cacheable access with no bus beats is a hit, answered in its first cycle
			if (!bypass && e.exp_rd == 0)
				check_eq(n, 1, $sformatf("entry %0d hit acknowledge cycle", i));
			// The acknowledge is a single cycle pulse
			check_eq(cpu_ack, 1'b0, $sformatf("entry %0d acknowledge length", i));
		end
		check_eq(rd_cnt - rd0, e.exp_rd, $sformatf("entry %0d bus read beats", i));
		if (e.exp_wr >= 0) begin
			check_eq(wr_cnt - wr0, e.exp_wr, $sformatf("entry %0d bus write beats", i));
			check_eq(att_cnt - att0, e.exp_rd + e.exp_wr + e.err,
				$sformatf("entry %0d bus attempts", i));
		end else begin
			// A victim goes out as two beats or not at all
			check_eq((wr_cnt - wr0) % 2, 0, $sformatf("entry %0d write-back beats", i));
			evict_wr += wr_cnt - wr0;
		end
	endtask

	// Watch every bus cycle of the DUT
	always @(negedge clk) begin
		if (rst === 1'b0) begin
			// The strobe rises and falls together with the cycle
			check_eq(bus_stb, bus_cyc, "bus stb against cyc");
			// Every bus write must carry what the CPU last stored at that beat
			if (bus_cyc && bus_we && bus_ack) begin
				check_eq(bus_wdat, cpu_view[bus_adr[13:4]], "bus write beat data");
				mem_view[bus_adr[13:4]] = cpu_view[bus_adr[13:4]];
			end
			// A read beat only ever fetches from the line of the access in progress
			if (bus_cyc && !bus_we && (bus_ack || bus_err))
				check_eq(bus_adr[31:5], cpu_adr[31:5], "bus read beat line address");
		end
	end

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial begin
		int n;
		dce        = 1'b1;
		cpu_cyc    = 1'b0;
		cpu_we     = 1'b0;
		cpu_attr   = CACHEABLE;
		cpu_adr    = '0;
		cpu_wdat   = '0;
		snoop_v    = 1'b0;
		snoop_adr  = '0;
		err_arm    = 1'b0;
		bd_we      = 1'b0;
		bd_adr     = '0;
		bd_dat     = '0;
		rng        = 32'd33012;
		n_entries  = 0;
		checks     = 0;
		mismatches = 0;
		timeouts   = 0;
		evict_wr   = 0;
		for (int i = 0; i < 1024; i++) begin
			cpu_view[i] = initial_beat({18'b0, 10'(i), 4'h0});
			mem_view[i] = initial_beat({18'b0, 10'(i), 4'h0});
		end
		build_table();
		n = 0;
		while (rst !== 1'b0 && n < 100) begin
			@(posedge clk);
			n++;
		end
		if (rst !== 1'b0) begin
			timeouts++;
			$display("Timeout: reset was never released");
		end else begin
			for (int i = 0; i < n_entries; i++)
				run_entry(i);
		end
		// Set 3 held four dirty lines, so at least one had to be written back
		check_eq(evict_wr >= 2, 1'b1, "dirty victim written back");
		$display("Checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/bus_mem_model.sv */
// ==========================================================
// Bus slave memory for the data cache testbench: pattern
// content, backdoor writes, error injection and beat counters
// ==========================================================
`default_nettype none

module bus_mem_model (
	input  wire logic         clk_i,
	input  wire logic         rst_i,
	input  wire logic         cyc_i,
	input  wire logic         stb_i,
	input  wire logic         we_i,
	input  wire logic [31:0]  adr_i,
	input  wire logic [127:0] dat_i,
	output logic              ack_o,
	output logic              err_o,
	output logic [127:0]      dat_o,
	input  wire logic         err_arm_i,
	input  wire logic         bd_we_i,
	input  wire logic [31:0]  bd_adr_i,
	input  wire logic [127:0] bd_dat_i,
	output int                rd_cnt_o,
	output int                wr_cnt_o,
	output int                att_cnt_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// 16 KB of beats; anything never written reads as the pattern
	logic [127:0] mem     [1024];
	logic         written [1024];
	logic         armed;
	logic [9:0]   idx;
	logic [9:0]   bd_idx;

	assign idx    = adr_i[13:4];
	assign bd_idx = bd_adr_i[13:4];

	// Content of an unwritten beat, built from every bit of its address
	function automatic logic [127:0] fill_pattern(input logic [31:0] adr);
		logic [31:0] b;
		b = {adr[31:4], 4'h0};
		return {b ^ 32'hC3A5_1E0F, b + 32'h0101_0101, ~b, b};
	endfunction

	always @(posedge clk_i) begin
		if (rst_i) begin
			ack_o     <= 1'b0;
			err_o     <= 1'b0;
			armed     <= 1'b0;
			rd_cnt_o  <= 0;
			wr_cnt_o  <= 0;
			att_cnt_o <= 0;
			for (int i = 0; i < 1024; i++)
				written[i] <= 1'b0;
		end else begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			// An armed error hits the next beat attempt only
			if (err_arm_i)
				armed <= 1'b1;
			if (bd_we_i) begin
				mem[bd_idx]     <= bd_dat_i;
				written[bd_idx] <= 1'b1;
			end
			// Answer once per beat, then wait for the master to drop cyc
			if (cyc_i && stb_i && !ack_o && !err_o) begin
				att_cnt_o <= att_cnt_o + 1;
				if (armed) begin
					err_o <= 1'b1;
					armed <= 1'b0;
				end else begin
					ack_o <= 1'b1;
					if (we_i) begin
						mem[idx]     <= dat_i;
						written[idx] <= 1'b1;
						wr_cnt_o     <= wr_cnt_o + 1;
					end else begin
						dat_o    <= written[idx] ? mem[idx] : fill_pattern(adr_i);
						rd_cnt_o <= rd_cnt_o + 1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
// ==========================================================
// Testbench clock and reset: 40 ns period, reset held high
// for the first 10 cycles
// ==========================================================
`default_nettype none

module tb_clkgen (
	output logic clk_o,
	output logic rst_o
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o;
	end

	// Release lands on a rising edge, like every other testbench drive
	initial begin
		rst_o = 1'b1;
		repeat (10) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

/* source/dcache_top.sv */
// ==========================================================
// Data cache top level: controller and arrays on plain CPU,
// bus and snoop ports
// ==========================================================
`default_nettype none

module dcache_top
	import bus_pkg::*;
(
	input  wire logic                  clk_i,
	input  wire logic                  rst_i,
	input  wire logic                  dce_i,
	input  wire logic                  cpu_cyc_i,
	input  wire logic                  cpu_we_i,
	input  wire cache_attr_t           cpu_attr_i,
	input  wire logic [ADDR_W-1:0]     cpu_adr_i,
	input  wire logic [BUS_DATA_W-1:0] cpu_dat_i,
	output logic                       cpu_ack_o,
	output logic [BUS_DATA_W-1:0]      cpu_dat_o,
	output logic                       bus_cyc_o,
	output logic                       bus_stb_o,
	output logic                       bus_we_o,
	output logic [ADDR_W-1:0]          bus_adr_o,
	output logic [BUS_DATA_W-1:0]      bus_dat_o,
	input  wire logic                  bus_ack_i,
	input  wire logic                  bus_err_i,
	input  wire logic [BUS_DATA_W-1:0] bus_dat_i,
	input  wire logic                  snoop_v_i,
	input  wire logic [ADDR_W-1:0]     snoop_adr_i
);

	bus_req_t  bus_req;
	bus_resp_t bus_resp;

	// Strobes and lookup results between controller and arrays
	dcache_array_if arr_if ();

	// Bus ports are plain at this level and structs inside
	assign bus_cyc_o = bus_req.cyc;
	assign bus_stb_o = bus_req.stb;
	assign bus_we_o  = bus_req.we;
	assign bus_adr_o = bus_req.adr;
	assign bus_dat_o = bus_req.dat;

	assign bus_resp.ack = bus_ack_i;
	assign bus_resp.err = bus_err_i;
	assign bus_resp.dat = bus_dat_i;

	dcache_ctrl u_ctrl (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.dce_i       (dce_i),
		.cpu_cyc_i   (cpu_cyc_i),
		.cpu_we_i    (cpu_we_i),
		.cpu_attr_i  (cpu_attr_i),
		.cpu_adr_i   (cpu_adr_i),
		.cpu_dat_i   (cpu_dat_i),
		.cpu_ack_o   (cpu_ack_o),
		.cpu_dat_o   (cpu_dat_o),
		.bus_req_o   (bus_req),
		.bus_resp_i  (bus_resp),
		.snoop_v_i   (snoop_v_i),
		.snoop_adr_i (snoop_adr_i),
		.arr         (arr_if.ctrl)
	);

	// The snoop goes to both blocks: arrays invalidate, controller restarts
	dcache_arrays u_arrays (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.arr         (arr_if.arrays),
		.snoop_v_i   (snoop_v_i),
		.snoop_adr_i (snoop_adr_i)
	);

endmodule

`default_nettype wire

/* dcache/dcache_ctrl.sv */
// ==========================================================
// Data cache controller: hit acknowledge, victim write-back,
// line fill, non-cacheable bypass and bus error retry
// ==========================================================
`default_nettype none

module dcache_ctrl
	import bus_pkg::*;
	import dcache_pkg::*;
(
	input  wire logic                  clk_i,
	input  wire logic                  rst_i,
	input  wire logic                  dce_i,
	input  wire logic                  cpu_cyc_i,
	input  wire logic                  cpu_we_i,
	input  wire cache_attr_t           cpu_attr_i,
	input  wire logic [ADDR_W-1:0]     cpu_adr_i,
	input  wire logic [BUS_DATA_W-1:0] cpu_dat_i,
	output logic                       cpu_ack_o,
	output logic [BUS_DATA_W-1:0]      cpu_dat_o,
	output bus_req_t                   bus_req_o,
	input  wire bus_resp_t             bus_resp_i,
	input  wire logic                  snoop_v_i,
	input  wire logic [ADDR_W-1:0]     snoop_adr_i,
	dcache_array_if.ctrl               arr
);

	typedef enum logic [2:0] {
		IDLE, WB0, WB1, LD0, LD1, BYP, BACKOFF
	} state_t;

	state_t                  state_q;
	state_t                  ret_q;
	state_t                  next_beat;
	bus_req_t                req_q;
	logic [16:0]             lfsr_q;
	logic [WAY_W-1:0]        way_q;
	logic [BACKOFF_MASK-1:0] wait_q;
	logic                    ack_q;
	logic [BUS_DATA_W-1:0]   byp_dat_q;

	logic                    cacheable;
	logic                    hit_ack;
	logic                    in_fill;
	logic                    filling;
	logic                    beat_done;
	logic                    snoop_restart;
	logic                    beat_we;
	logic [ADDR_W-1:0]       beat_adr;
	logic [BUS_DATA_W-1:0]   beat_dat;

	// ==========================================================
	// Access decode and CPU response
	// ==========================================================

	// Only an enabled cache with an allocating attribute uses the arrays
	assign cacheable = dce_i && (cpu_attr_i == CACHEABLE || cpu_attr_i == CACHEABLE_NB);

	// A hit is answered in the same cycle; the cycle after a bypass ack is skipped
	assign hit_ack = (state_q == IDLE) && cpu_cyc_i && !ack_q && cacheable && arr.hit;

	assign cpu_ack_o = hit_ack || ack_q;
	assign cpu_dat_o = ack_q ? byp_dat_q : arr.hit_line.half[cpu_adr_i[HALF_BIT]];

	// ==========================================================
	// Array strobes
	// ==========================================================

	assign in_fill   = (state_q == LD0) || (state_q == LD1);
	assign beat_done = req_q.cyc && bus_resp_i.ack;

	assign arr.idx = cpu_adr_i[IDX_HI:IDX_LO];
	assign arr.tag = cpu_adr_i[TAG_LO +: TAG_W];

	// In IDLE the LFSR offers a way so its victim flags can be inspected
	assign arr.way = (state_q == IDLE) ? lfsr_q[WAY_W-1:0] : way_q;

	// Fill beats and CPU writes share the data path into the arrays
	assign arr.fill_half = in_fill ? (state_q == LD1) : cpu_adr_i[HALF_BIT];
	assign arr.fill_dat  = in_fill ? bus_resp_i.dat : cpu_dat_i;

	// A snoop on the set being filled cancels the array writes of that cycle
	assign arr.fill_we     = in_fill && beat_done && !snoop_restart;
	assign arr.fill_tag_we = (state_q == LD1) && beat_done && !snoop_restart;
	assign arr.hit_we      = hit_ack && cpu_we_i;

	// Any miss handling state, including a wait after a failed miss beat
	assign filling = (state_q == WB0) || (state_q == WB1) || in_fill ||
		((state_q == BACKOFF) && (ret_q != BYP));

	// Only the index is compared, as in the arrays a tag match decides
	assign snoop_restart = snoop_v_i && filling &&
		(snoop_adr_i[IDX_HI:IDX_LO] == cpu_adr_i[IDX_HI:IDX_LO]);

	// ==========================================================
	// Bus beat contents
	// ==========================================================

	always_comb begin
		beat_we   = 1'b0;
		beat_adr  = {cpu_adr_i[ADDR_W-1:IDX_LO], 1'b0, {HALF_BIT{1'b0}}};
		beat_dat  = arr.victim_line.half[0];
		next_beat = IDLE;
		case (state_q)
			WB0: begin
				beat_we   = 1'b1;
				beat_adr  = {arr.victim_tag, arr.idx, 1'b0, {HALF_BIT{1'b0}}};
				next_beat = WB1;
			end
			WB1: begin
				beat_we   = 1'b1;
				beat_adr  = {arr.victim_tag, arr.idx, 1'b1, {HALF_BIT{1'b0}}};
				beat_dat  = arr.victim_line.half[1];
				next_beat = LD0;
			end
			LD0: next_beat = LD1;
			LD1: begin
				beat_adr = {cpu_adr_i[ADDR_W-1:IDX_LO], 1'b1, {HALF_BIT{1'b0}}};
				// Back to IDLE, where the access now hits
				next_beat = IDLE;
			end
			BYP: begin
				beat_we  = cpu_we_i;
				beat_adr = cpu_adr_i;
				beat_dat = cpu_dat_i;
			end
			default: ;
		endcase
	end

	assign bus_req_o = req_q;

	// ==========================================================
	// State machine
	// ==========================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q   <= IDLE;
			ret_q     <= IDLE;
			req_q.cyc <= 1'b0;
			req_q.stb <= 1'b0;
			req_q.we  <= 1'b0;
			ack_q     <= 1'b0;
			way_q     <= '0;
			wait_q    <= '0;
			lfsr_q    <= 17'h1;
		end else begin
			// Maximal length 17-bit LFSR, taps 17 and 14
			lfsr_q <= {lfsr_q[15:0], lfsr_q[16] ^ lfsr_q[13]};
			ack_q  <= 1'b0;
			case (state_q)
				IDLE: begin
					// The cycle of a bypass ack still sees the old cyc
					if (cpu_cyc_i && !ack_q) begin
						if (!cacheable) begin
							state_q <= BYP;
						end else if (!arr.hit) begin
							way_q <= arr.way;
							// Write back only if the victim holds modified data
							if (arr.victim_valid && arr.victim_dirty)
								state_q <= WB0;
							else
								state_q <= LD0;
						end
					end
				end
				WB0, WB1, LD0, LD1, BYP: begin
					if (!req_q.cyc) begin
						// Raise the beat and hold it until the slave answers
						req_q.cyc <= 1'b1;
						req_q.stb <= 1'b1;
						req_q.we  <= beat_we;
						req_q.adr <= beat_adr;
						req_q.dat <= beat_dat;
					end else if (bus_resp_i.ack || bus_resp_i.err) begin
						req_q.cyc <= 1'b0;
						req_q.stb <= 1'b0;
						req_q.we  <= 1'b0;
						if (bus_resp_i.err) begin
							// Retry the same beat after a random pause
							ret_q   <= state_q;
							wait_q  <= lfsr_q[WAY_W +: BACKOFF_MASK];
							state_q <= BACKOFF;
						end else begin
							state_q <= next_beat;
							ack_q   <= (state_q == BYP);
						end
					end
				end
				BACKOFF: begin
					if (wait_q == '0)
						state_q <= ret_q;
					else
						wait_q <= wait_q - 1'b1;
				end
				default: state_q <= IDLE;
			endcase
			// The line under fill changed; start the access over
			if (snoop_restart) begin
				req_q.cyc <= 1'b0;
				req_q.stb <= 1'b0;
				req_q.we  <= 1'b0;
				state_q   <= IDLE;
			end
		end
	end

	// Read data of a bypass beat, returned one cycle after the bus ack
	always_ff @(posedge clk_i) begin
		if ((state_q == BYP) && beat_done)
			byp_dat_q <= bus_resp_i.dat;
	end

endmodule

`default_nettype wire

/* dcache/dcache_arrays.sv */
// ==========================================================
// Tag, valid, dirty and line storage of the data cache, with
// hit lookup, victim read-out and snoop invalidation
// ==========================================================
`default_nettype none

module dcache_arrays
	import bus_pkg::*;
	import dcache_pkg::*;
(
	input  wire logic              clk_i,
	input  wire logic              rst_i,
	dcache_array_if.arrays         arr,
	input  wire logic              snoop_v_i,
	input  wire logic [ADDR_W-1:0] snoop_adr_i
);

	// Storage is kept in flops so that every read is asynchronous
	logic [TAG_W-1:0] tag_q   [SETS][WAYS];
	logic             valid_q [SETS][WAYS];
	logic             dirty_q [SETS][WAYS];
	dcache_line_u     data_q  [SETS][WAYS];

	logic [WAYS-1:0]  hit_vec;
	logic [WAY_W-1:0] hit_way;
	logic [IDX_W-1:0] snoop_idx;
	logic [TAG_W-1:0] snoop_tag;

	assign snoop_idx = snoop_adr_i[IDX_HI:IDX_LO];
	assign snoop_tag = snoop_adr_i[TAG_LO +: TAG_W];

	// ==========================================================
	// Lookup
	// ==========================================================

	// Compare the request tag against all four ways of the set
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			hit_vec[w] = valid_q[arr.idx][w] && (tag_q[arr.idx][w] == arr.tag);
			// Only one way can match, since a fill always replaces a miss
			if (hit_vec[w])
				hit_way = WAY_W'(w);
		end
	end

	assign arr.hit      = |hit_vec;
	assign arr.hit_line = data_q[arr.idx][hit_way];

	// The controller picks the way; its contents are the candidate victim
	assign arr.victim_line  = data_q[arr.idx][arr.way];
	assign arr.victim_tag   = tag_q[arr.idx][arr.way];
	assign arr.victim_dirty = dirty_q[arr.idx][arr.way];
	assign arr.victim_valid = valid_q[arr.idx][arr.way];

	// ==========================================================
	// Line data and tags
	// ==========================================================

	always_ff @(posedge clk_i) begin
		// One half of the chosen way arrives per bus load beat
		if (arr.fill_we)
			data_q[arr.idx][arr.way].half[arr.fill_half] <= arr.fill_dat;
		// A CPU write hit updates one half of the matching way
		if (arr.hit_we)
			data_q[arr.idx][hit_way].half[arr.fill_half] <= arr.fill_dat;
		// The tag is written together with the last fill beat
		if (arr.fill_tag_we)
			tag_q[arr.idx][arr.way] <= arr.tag;
	end

	// ==========================================================
	// Valid and dirty flags
	// ==========================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					valid_q[s][w] <= 1'b0;
					dirty_q[s][w] <= 1'b0;
				end
			end
		end else begin
			// A freshly loaded line is clean
			if (arr.fill_tag_we) begin
				valid_q[arr.idx][arr.way] <= 1'b1;
				dirty_q[arr.idx][arr.way] <= 1'b0;
			end
			// The line now differs from memory
			if (arr.hit_we)
				dirty_q[arr.idx][hit_way] <= 1'b1;
			// Snoop comes last so that it wins over a fill in the same cycle
			if (snoop_v_i) begin
				for (int w = 0; w < WAYS; w++) begin
					if (valid_q[snoop_idx][w] && (tag_q[snoop_idx][w] == snoop_tag))
						valid_q[snoop_idx][w] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* common/dcache_array_if.sv */
// ==========================================================
// Strobes and levels between the cache controller and the
// tag and data arrays
// ==========================================================
`default_nettype none

interface dcache_array_if
	import bus_pkg::*;
	import dcache_pkg::*;
();

	// Request side, driven by the controller
	logic [IDX_W-1:0]      idx;
	logic [TAG_W-1:0]      tag;
	logic [WAY_W-1:0]      way;
	logic                  fill_we;
	logic                  fill_half;
	logic [BUS_DATA_W-1:0] fill_dat;
	logic                  fill_tag_we;
	logic                  hit_we;

	// Lookup results, driven by the arrays
	logic                  hit;
	dcache_line_u          hit_line;
	dcache_line_u          victim_line;
	logic [TAG_W-1:0]      victim_tag;
	logic                  victim_dirty;
	logic                  victim_valid;

	modport ctrl (
		output idx, tag, way, fill_we, fill_half, fill_dat, fill_tag_we, hit_we,
		input  hit, hit_line, victim_line, victim_tag, victim_dirty, victim_valid
	);

	modport arrays (
		input  idx, tag, way, fill_we, fill_half, fill_dat, fill_tag_we, hit_we,
		output hit, hit_line, victim_line, victim_tag, victim_dirty, victim_valid
	);

endinterface

`default_nettype wire

/* common/dcache_pkg.sv */
// ==========================================================
// Data cache geometry, address field positions and the
// cache line type
// ==========================================================
`default_nettype none

package dcache_pkg;

	import bus_pkg::*;

	// Four ways, so a way number fits in two bits
	localparam int WAYS  = 4;
	localparam int WAY_W = 2;

	// Sixteen sets of 32-byte lines
	localparam int SETS = 16;

	// Address bit 4 picks the lower or upper 128-bit half of a line
	localparam int HALF_BIT = 4;

	// Index field of the byte address
	localparam int IDX_LO = 5;
	localparam int IDX_HI = 8;
	localparam int IDX_W  = IDX_HI - IDX_LO + 1;

	// Everything above the index is tag
	localparam int TAG_LO = 9;
	localparam int TAG_W  = 23;

	// Width of the random wait after a bus error
	localparam int BACKOFF_MASK = 3;

	// A line is stored and copied whole, but filled, written back and
	// written by the CPU one bus beat at a time
	typedef union packed {
		logic [2*BUS_DATA_W-1:0]     line;
		logic [1:0][BUS_DATA_W-1:0] half;
	} dcache_line_u;

endpackage

`default_nettype wire

/* common/bus_pkg.sv */
// ==========================================================
// System bus definitions shared by the data cache and its
// bus master: widths, access attributes, request and response
// ==========================================================
`default_nettype none

package bus_pkg;

	// ==========================================================
	// Widths
	// ==========================================================

	// Width of one bus beat, which is half a cache line
	localparam int BUS_DATA_W = 128;

	// Byte address width on both the CPU and the bus side
	localparam int ADDR_W = 32;

	// ==========================================================
	// Access attributes
	// ==========================================================

	// Attribute carried with every CPU access
	// NON_CACHEABLE goes straight to the bus, the other two allocate
	typedef enum logic [1:0] {
		NON_CACHEABLE = 2'd0,
		CACHEABLE     = 2'd1,
		CACHEABLE_NB  = 2'd2
	} cache_attr_t;

	// ==========================================================
	// Bus request and response
	// ==========================================================

	// Master side of a single bus beat
	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [ADDR_W-1:0]     adr;
		logic [BUS_DATA_W-1:0] dat;
	} bus_req_t;

	// Slave side; ack or err ends the beat
	typedef struct packed {
		logic                  ack;
		logic                  err;
		logic [BUS_DATA_W-1:0] dat;
	} bus_resp_t;

endpackage

`default_nettype wire
